// ==== source/copp_isa_pkg.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// slim copper instruction set: opcodes,
// field positions, word types, FSM states
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

package copp_isa_pkg;

    localparam int WORD_W      = 16;        // copper and XR data width
    localparam int COPP_ADDR_W = 11;        // copper memory is 2K words

    typedef logic [WORD_W-1:0]      word_t;         // program word / XR data
    typedef logic [COPP_ADDR_W-1:0] copp_addr_t;    // copper address or PC

    // opcode table (bits 13:12 select the class)
    //   rr00 oooo oooo oooo + im16      SETI   xadr14,#im16
    //   --01 rccc cccc cccc + xadr16    SETM   xadr16,cadr11  (r=1 reads RA)
    //   --10 0iii iiii iiii             HPOS   #im11
    //   --10 1iii iiii iiii             VPOS   #im11
    //   --11 0ccc cccc cccc             BRGE   cadd11  (taken when B=0)
    //   --11 1ccc cccc cccc             BRLT   cadd11  (taken when B=1)
    typedef enum logic [1:0] {
        OP_SETI  = 2'b00,                   // two words, immediate source
        OP_SETM  = 2'b01,                   // two words, memory or RA source
        OP_HVPOS = 2'b10,                   // beam wait
        OP_BRCC  = 2'b11                    // conditional branch on B
    } copp_op_t;

    localparam int B_OPCODE  = 12;          // 2-bit opcode field base
    localparam int B_HV_SEL  = 11;          // 0=HPOS, 1=VPOS
    localparam int B_HV_POS  = 10;          // msb of 11-bit beam target
    localparam int B_BR_SEL  = 11;          // 0=BRGE, 1=BRLT
    localparam int B_BR_ADR  = 10;          // msb of branch address
    localparam int B_COP_REG = 11;          // pseudo register select
    localparam int B_RA_SUB  = 0;           // RA load (0) or subtract (1)

    // config region holds the RA pseudo registers when B_COP_REG is set
    localparam logic [1:0] XR_CONFIG_REGION = 2'b00;
    localparam logic [11:0] RA_LOAD_OFFSET  = 12'h800;  // RA = val16
    localparam logic [11:0] RA_SUB_OFFSET   = 12'h801;  // RA = RA - val16

    // execution state
    typedef enum logic [1:0] {
        ST_FETCH   = 2'b00,                 // read opcode, or stall on beam wait
        ST_DECODE  = 2'b01,                 // act on IR
        ST_SETM_RD = 2'b10,                 // latch SETM destination word
        ST_SETM_WR = 2'b11                  // issue SETM write
    } copp_state_t;

endpackage

// ==== source/copp_bus_pkg.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// slim copper system side types:
// XR write, copper memory read, beam position
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

package copp_bus_pkg;

    typedef logic [15:0] xr_addr_t;         // region in 15:14, offset below
    typedef logic [10:0] hres_t;            // horizontal beam count
    typedef logic [10:0] vres_t;            // vertical beam count

    // XR register bus write, held until ack
    typedef struct packed {
        logic                   en;         // write pending
        xr_addr_t               addr;
        copp_isa_pkg::word_t    data;
    } xr_wr_t;

    // copper memory read request, data valid next cycle
    typedef struct packed {
        logic                     en;
        copp_isa_pkg::copp_addr_t addr;
    } copmem_rd_t;

    // beam position from the video timing block
    typedef struct packed {
        hres_t h;
        vres_t v;
        logic  end_of_line;                 // last pixel of the line
    } video_pos_t;

endpackage

// ==== source/copp_ctrl.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// copper enable register and the
// per-frame run/clear control
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none
`timescale 1ns/1ps

module copp_ctrl (
    input  wire logic                     clk,
    input  wire logic                     cop_reset,
    input  wire logic                     cop_xreg_wr_i,      // control register write strobe
    input  wire logic                     cop_xreg_enable_i,  // enable bit of the write
    input  wire copp_bus_pkg::video_pos_t video_i,
    output      logic                     seq_clear_o         // holds sequencer at PC 0
);

    logic cop_en;                           // enable bit as written by software
    logic cop_run;                          // running this frame
    logic sof;

    // start of frame is the end of line 0
    assign sof = video_i.end_of_line && (video_i.v == '0);

    always_ff @(posedge clk) begin
        if (cop_reset) begin
            cop_en      <= 1'b0;
            cop_run     <= 1'b0;
            seq_clear_o <= 1'b1;            // keep sequencer idle out of reset
        end else begin
            if (sof) begin
                seq_clear_o <= 1'b1;        // restart program every frame
                cop_run     <= cop_en;      // enable only takes effect here
            end else begin
                seq_clear_o <= !cop_run;
            end

            if (cop_xreg_wr_i) begin
                cop_en <= cop_xreg_enable_i;
                if (!cop_xreg_enable_i) begin
                    cop_run <= 1'b0;        // disable stops at once
                end
            end
        end
    end

endmodule
`default_nettype wire

// ==== source/copp_hv_wait.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// HPOS/VPOS beam wait flag
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none
`timescale 1ns/1ps

module copp_hv_wait (
    input  wire logic                     clk,
    input  wire logic                     seq_clear_i,
    input  wire logic                     hv_arm_i,     // one cycle pulse from decode
    input  wire logic                     hv_sel_v_i,   // 1 = wait on vertical count
    input  wire copp_bus_pkg::hres_t      hv_target_i,  // 11-bit immediate
    input  wire copp_bus_pkg::video_pos_t video_i,
    output      logic                     hv_waiting_o
);

    logic wait_v;                           // selected count is v
    logic reached;                          // beam at or past target

    // unsigned compare, so VPOS #-1 never completes within a frame
    always_comb begin
        if (wait_v) begin
            reached = video_i.v >= copp_bus_pkg::vres_t'(hv_target_i);
        end else begin
            reached = video_i.h >= hv_target_i;
        end
    end

    always_ff @(posedge clk) begin
        if (seq_clear_i) begin
            hv_waiting_o <= 1'b0;
            wait_v       <= 1'b0;
        end else if (hv_arm_i) begin
            hv_waiting_o <= 1'b1;           // always wait at least one cycle
            wait_v       <= hv_sel_v_i;
        end else if (reached) begin
            hv_waiting_o <= 1'b0;           // release fetch
        end
    end

endmodule
`default_nettype wire

// ==== source/copp_ra_unit.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// RA accumulator with borrow flag
// from an unsigned subtract
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none
`timescale 1ns/1ps

module copp_ra_unit (
    input  wire logic                clk,
    input  wire logic                seq_clear_i,
    input  wire logic                ra_wr_en_i,    // pseudo register write pulse
    input  wire logic                ra_sub_i,      // 1 = RA_SUB, 0 = RA load
    input  wire copp_isa_pkg::word_t wr_data_i,     // last value written by copper
    output      copp_isa_pkg::word_t ra_o,
    output      logic                borrow_o       // B flag
);

    copp_isa_pkg::word_t ra_q;
    copp_isa_pkg::word_t diff;              // RA - wr_data

    // 17-bit subtract, msb is the borrow
    // B tracks the live RA against the value last written
    assign {borrow_o, diff} = {1'b0, ra_q} - {1'b0, wr_data_i};

    assign ra_o = ra_q;

    always_ff @(posedge clk) begin
        if (seq_clear_i) begin
            ra_q <= '0;                     // RA starts at 0 each frame
        end else if (ra_wr_en_i) begin
            if (ra_sub_i) begin
                ra_q <= diff;               // RA_SUB
            end else begin
                ra_q <= wr_data_i;          // plain load
            end
        end
    end

endmodule
`default_nettype wire

// ==== source/copp_sequencer.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// copper fetch/decode/execute FSM,
// drives copper memory reads and XR writes
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none
`timescale 1ns/1ps

module copp_sequencer (
    input  wire logic                     clk,
    input  wire logic                     seq_clear_i,
    output      copp_bus_pkg::copmem_rd_t copmem_rd_o,
    input  wire copp_isa_pkg::word_t      copmem_rd_data_i,  // valid cycle after en
    output      copp_bus_pkg::xr_wr_t     xr_wr_o,
    input  wire logic                     xr_wr_ack_i,
    input  wire copp_isa_pkg::word_t      ra_i,
    input  wire logic                     borrow_i,
    output      logic                     ra_wr_en_o,
    output      logic                     ra_sub_o,
    output      copp_isa_pkg::word_t      wr_data_o,
    input  wire logic                     hv_waiting_i,
    output      logic                     hv_arm_o,
    output      logic                     hv_sel_v_o,
    output      copp_bus_pkg::hres_t      hv_target_o
);

    copp_isa_pkg::copp_state_t state;
    copp_isa_pkg::copp_op_t    op;
    copp_isa_pkg::copp_addr_t  pc;
    copp_isa_pkg::copp_addr_t  pc_next;
    copp_isa_pkg::word_t       ir;          // opcode, then SETM destination
    copp_bus_pkg::copmem_rd_t  rd_q;
    copp_bus_pkg::xr_wr_t      wr_q;
    logic                      rd_pipe;     // read data valid this cycle
    logic                      src_ra;      // SETM source is RA
    logic                      reg_wr_en;   // pseudo register write

    // destination in config region with the cop reg bit goes to RA
    function automatic logic is_ra_dest(copp_bus_pkg::xr_addr_t a);
        return (a[15:14] == copp_isa_pkg::XR_CONFIG_REGION) && a[copp_isa_pkg::B_COP_REG];
    endfunction

    assign op      = copp_isa_pkg::copp_op_t'(ir[copp_isa_pkg::B_OPCODE +: 2]);
    assign pc_next = pc + 1'b1;

    assign copmem_rd_o = rd_q;
    assign xr_wr_o     = wr_q;
    assign ra_wr_en_o  = reg_wr_en;
    assign ra_sub_o    = wr_q.addr[copp_isa_pkg::B_RA_SUB];  // 0x801 subtracts
    assign wr_data_o   = wr_q.data;         // also the compare operand for B

    // beam wait, armed straight from decode so fetch sees it next cycle
    assign hv_arm_o    = (state == copp_isa_pkg::ST_DECODE) && (op == copp_isa_pkg::OP_HVPOS);
    assign hv_sel_v_o  = ir[copp_isa_pkg::B_HV_SEL];
    assign hv_target_o = ir[copp_isa_pkg::B_HV_POS:0];

    always_ff @(posedge clk) begin
        if (seq_clear_i) begin
            state     <= copp_isa_pkg::ST_FETCH;
            pc        <= '0;
            rd_q      <= '0;
            wr_q      <= '0;
            rd_pipe   <= 1'b0;
            src_ra    <= 1'b0;
            reg_wr_en <= 1'b0;
        end else begin
            rd_q.en   <= 1'b0;              // strobes default off
            rd_q.addr <= pc;                // most reads are at PC
            reg_wr_en <= 1'b0;
            rd_pipe   <= rd_q.en;

            if (xr_wr_ack_i) begin
                wr_q.en <= 1'b0;            // hold write until acked
            end

            case (state)
                copp_isa_pkg::ST_FETCH: begin
                    if (!rd_pipe) begin
                        // stalled on beam wait, or read already out
                        if (!hv_waiting_i && !rd_q.en) begin
                            rd_q.en <= 1'b1;
                            pc      <= pc_next;
                        end
                    end else begin
                        ir <= copmem_rd_data_i;
                        // SETI/SETM have a second word, read it now
                        if (!copmem_rd_data_i[copp_isa_pkg::B_OPCODE+1]) begin
                            rd_q.en <= 1'b1;
                            pc      <= pc_next;
                        end
                        state <= copp_isa_pkg::ST_DECODE;
                    end
                end
                copp_isa_pkg::ST_DECODE: begin
                    case (op)
                        copp_isa_pkg::OP_SETI: begin
                            if (rd_pipe) begin      // im16 arrived
                                wr_q.addr <= ir;    // opcode bits are 00, so ir is the address
                                wr_q.data <= copmem_rd_data_i;
                                if (is_ra_dest(ir)) begin
                                    reg_wr_en <= 1'b1;
                                end else begin
                                    wr_q.en   <= 1'b1;
                                end
                                rd_q.en <= 1'b1;    // next fetch overlaps the write
                                pc      <= pc_next;
                                state   <= copp_isa_pkg::ST_FETCH;
                            end
                        end
                        copp_isa_pkg::OP_SETM: begin
                            rd_q.en   <= 1'b1;      // source read, unused if RA
                            rd_q.addr <= ir[copp_isa_pkg::COPP_ADDR_W-1:0];
                            src_ra    <= ir[copp_isa_pkg::B_COP_REG];
                            state     <= copp_isa_pkg::ST_SETM_RD;
                        end
                        copp_isa_pkg::OP_HVPOS: begin
                            state <= copp_isa_pkg::ST_FETCH;    // wait flag holds fetch
                        end
                        copp_isa_pkg::OP_BRCC: begin
                            // BRGE on B=0, BRLT on B=1
                            if (borrow_i == ir[copp_isa_pkg::B_BR_SEL]) begin
                                pc <= ir[copp_isa_pkg::B_BR_ADR:0];
                            end
                            state <= copp_isa_pkg::ST_FETCH;
                        end
                    endcase
                end
                copp_isa_pkg::ST_SETM_RD: begin
                    ir      <= copmem_rd_data_i;    // destination word
                    rd_q.en <= 1'b1;                // early fetch of next opcode
                    state   <= copp_isa_pkg::ST_SETM_WR;
                end
                copp_isa_pkg::ST_SETM_WR: begin
                    wr_q.addr <= ir;
                    wr_q.data <= src_ra ? ra_i : copmem_rd_data_i;
                    if (is_ra_dest(ir)) begin
                        reg_wr_en <= 1'b1;
                    end else begin
                        wr_q.en   <= 1'b1;
                    end
                    pc    <= pc_next;
                    state <= copp_isa_pkg::ST_FETCH;
                end
            endcase
        end
    end

endmodule
`default_nettype wire

// ==== source/slim_copper.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// slim copper top, beam-timed XR
// register writer
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none
`timescale 1ns/1ps

module slim_copper (
    input  wire logic                     clk,
    input  wire logic                     cop_reset,
    output      copp_bus_pkg::copmem_rd_t copmem_rd_o,
    input  wire copp_isa_pkg::word_t      copmem_rd_data_i,
    output      copp_bus_pkg::xr_wr_t     xr_wr_o,
    input  wire logic                     xr_wr_ack_i,
    input  wire logic                     cop_xreg_wr_i,
    input  wire logic                     cop_xreg_enable_i,
    input  wire copp_bus_pkg::video_pos_t video_i
);

    logic                seq_clear;
    logic                ra_wr_en;
    logic                ra_sub;
    copp_isa_pkg::word_t wr_data;
    copp_isa_pkg::word_t ra;
    logic                borrow;
    logic                hv_arm;
    logic                hv_sel_v;
    copp_bus_pkg::hres_t hv_target;
    logic                hv_waiting;

    copp_ctrl copp_ctrl_inst (
        .clk               (clk),
        .cop_reset         (cop_reset),
        .cop_xreg_wr_i     (cop_xreg_wr_i),
        .cop_xreg_enable_i (cop_xreg_enable_i),
        .video_i           (video_i),
        .seq_clear_o       (seq_clear)
    );

    copp_sequencer copp_sequencer_inst (
        .clk              (clk),
        .seq_clear_i      (seq_clear),
        .copmem_rd_o      (copmem_rd_o),
        .copmem_rd_data_i (copmem_rd_data_i),
        .xr_wr_o          (xr_wr_o),
        .xr_wr_ack_i      (xr_wr_ack_i),
        .ra_i             (ra),
        .borrow_i         (borrow),
        .ra_wr_en_o       (ra_wr_en),
        .ra_sub_o         (ra_sub),
        .wr_data_o        (wr_data),
        .hv_waiting_i     (hv_waiting),
        .hv_arm_o         (hv_arm),
        .hv_sel_v_o       (hv_sel_v),
        .hv_target_o      (hv_target)
    );

    copp_ra_unit copp_ra_unit_inst (
        .clk         (clk),
        .seq_clear_i (seq_clear),
        .ra_wr_en_i  (ra_wr_en),
        .ra_sub_i    (ra_sub),
        .wr_data_i   (wr_data),
        .ra_o        (ra),
        .borrow_o    (borrow)
    );

    copp_hv_wait copp_hv_wait_inst (
        .clk          (clk),
        .seq_clear_i  (seq_clear),
        .hv_arm_i     (hv_arm),
        .hv_sel_v_i   (hv_sel_v),
        .hv_target_i  (hv_target),
        .video_i      (video_i),
        .hv_waiting_o (hv_waiting)
    );

endmodule
`default_nettype wire

// ==== bench/copper_tb_chk.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// slim copper bus protocol and
// beam timing assertions
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module copper_tb_chk (
    input wire logic                     clk,
    input wire logic                     cop_reset,
    input wire copp_bus_pkg::copmem_rd_t copmem_rd_i,
    input wire copp_bus_pkg::xr_wr_t     xr_wr_i,
    input wire logic                     xr_wr_ack_i,
    input wire logic                     cop_xreg_wr_i,
    input wire logic                     cop_xreg_enable_i,
    input wire copp_bus_pkg::video_pos_t video_i,
    input wire logic                     hv_arm_i,
    input wire logic                     hv_sel_v_i,
    input wire copp_bus_pkg::hres_t      hv_target_i
);

    logic                wr_en_q;           // en one cycle ago, for rise detect
    logic                h_armed;           // HPOS armed, no write issued since
    copp_bus_pkg::hres_t h_target_q;
    logic [1:0]          dis_sr;            // disable write delay line
    logic                quiet;             // copper must be idle
    logic                sof;

    assign sof = video_i.end_of_line && (video_i.v == '0);

    always_ff @(posedge clk) begin
        if (cop_reset) begin
            wr_en_q    <= 1'b0;
            h_armed    <= 1'b0;
            h_target_q <= '0;
            dis_sr     <= '0;
            quiet      <= 1'b0;
        end else begin
            wr_en_q <= xr_wr_i.en;
            if (hv_arm_i && !hv_sel_v_i) begin
                h_armed    <= 1'b1;
                h_target_q <= hv_target_i;
            end else if (sof || (xr_wr_i.en && !wr_en_q)) begin
                h_armed <= 1'b0;            // first write after the wait
            end
            dis_sr <= {dis_sr[0], cop_xreg_wr_i && !cop_xreg_enable_i};
            if (sof) begin
                quiet <= 1'b0;
            end else if (dis_sr[1]) begin
                quiet <= 1'b1;              // sequencer fully cleared by now
            end
        end
    end

    a_wr_hold: assert property (@(posedge clk) disable iff (cop_reset)
        xr_wr_i.en && !xr_wr_ack_i |=>
            xr_wr_i.en && $stable(xr_wr_i.addr) && $stable(xr_wr_i.data))
        else $error("XR write dropped or changed before its ack");

    a_quiet: assert property (@(posedge clk) disable iff (cop_reset)
        quiet |-> !copmem_rd_i.en && !xr_wr_i.en)
        else $error("copper active while disabled, before start of frame");

    a_hpos: assert property (@(posedge clk) disable iff (cop_reset)
        xr_wr_i.en && !wr_en_q && h_armed |-> video_i.h >= h_target_q)
        else $error("XR write issued before the HPOS target was reached");

endmodule

bind slim_copper copper_tb_chk copper_tb_chk_inst (
    .clk               (clk),
    .cop_reset         (cop_reset),
    .copmem_rd_i       (copmem_rd_o),
    .xr_wr_i           (xr_wr_o),
    .xr_wr_ack_i       (xr_wr_ack_i),
    .cop_xreg_wr_i     (cop_xreg_wr_i),
    .cop_xreg_enable_i (cop_xreg_enable_i),
    .video_i           (video_i),
    .hv_arm_i          (hv_arm),
    .hv_sel_v_i        (hv_sel_v),
    .hv_target_i       (hv_target)
);

// ==== bench/copper_tb.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// slim copper testbench: programs,
// memory, beam and XR target models
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module copper_tb;

    localparam int     CLK_PERIOD  = 100;
    localparam int     H_LAST      = 63;    // short line for simulation
    localparam int     V_LAST      = 524;
    localparam int     RUN_FRAMES  = 22;    // worst case over all tests
    localparam longint FRAME_NS    = longint'((H_LAST + 1) * (V_LAST + 1)) * CLK_PERIOD;
    localparam longint WATCHDOG_NS = RUN_FRAMES * FRAME_NS * 12 / 10;
    localparam logic [15:0] MARKER_ADDR = 16'h4021;

    logic                     clk;
    logic                     cop_reset;
    copp_bus_pkg::copmem_rd_t copmem_rd;
    copp_isa_pkg::word_t      copmem_rd_data;
    copp_bus_pkg::xr_wr_t     xr_wr;
    logic                     xr_wr_ack;
    logic                     cop_xreg_wr;
    logic                     cop_xreg_enable;
    copp_bus_pkg::video_pos_t video;

    copp_isa_pkg::word_t      mem [0:2047];  // copper program memory
    logic [31:0]              exp_q [$];     // expected {addr, data}
    copp_isa_pkg::copp_addr_t load_pc;
    copp_bus_pkg::hres_t      hpos_target;
    copp_bus_pkg::hres_t      beam_h;
    logic                     ack_busy;
    int                       ack_wait;

    slim_copper slim_copper_inst (
        .clk               (clk),
        .cop_reset         (cop_reset),
        .copmem_rd_o       (copmem_rd),
        .copmem_rd_data_i  (copmem_rd_data),
        .xr_wr_o           (xr_wr),
        .xr_wr_ack_i       (xr_wr_ack),
        .cop_xreg_wr_i     (cop_xreg_wr),
        .cop_xreg_enable_i (cop_xreg_enable),
        .video_i           (video)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // beam counter, end_of_line marks the last pixel
    initial begin
        video = '0;
        forever begin
            @(posedge clk);
            #5;
            if (video.end_of_line) begin
                video.h = '0;
                video.v = (video.v == V_LAST) ? '0 : video.v + 1'b1;
            end else begin
                video.h = video.h + 1'b1;
            end
            video.end_of_line = (video.h == H_LAST);
        end
    end

    // one cycle read latency
    initial begin
        copp_isa_pkg::copp_addr_t a;
        copmem_rd_data = '0;
        forever begin
            @(posedge clk);
            a = copmem_rd.addr;
            if (copmem_rd.en) begin
                #5 copmem_rd_data = mem[a];
            end
        end
    end

    // XR target, ack after 0 to 2 cycles
    initial begin
        xr_wr_ack = 1'b0;
        ack_busy  = 1'b0;
        ack_wait  = 0;
        forever begin
            @(posedge clk);
            beam_h = video.h;
            #5;
            if (xr_wr_ack) begin
                xr_wr_ack = 1'b0;           // en falls this cycle
                ack_busy  = 1'b0;
            end else if (xr_wr.en) begin
                if (!ack_busy) begin
                    ack_busy = 1'b1;
                    ack_wait = $urandom_range(2, 0);
                end
                if (ack_wait == 0) begin
                    xr_wr_ack = 1'b1;
                    check_write(xr_wr.addr, xr_wr.data, beam_h);
                end else begin
                    ack_wait--;
                end
            end
        end
    end

    initial begin
        #(WATCHDOG_NS);
        $display("watchdog expired, the copper stopped making progress");
        $display("Test failed");
        $fatal(1, "timeout");
    end

    function automatic copp_isa_pkg::word_t fill_word(input int a);
        return copp_isa_pkg::word_t'(a * 40503) ^ 16'h5A5A;  // odd multiplier, unique per address
    endfunction

    // HPOS/VPOS word, sel_v picks the vertical count
    function automatic copp_isa_pkg::word_t hv_word(input logic sel_v, input logic [10:0] n);
        return {4'b0010, sel_v, n};
    endfunction

    function automatic copp_isa_pkg::word_t brcc_word(input logic lt, input logic [10:0] a);
        return {4'b0011, lt, a};
    endfunction

    task automatic check_write(input copp_bus_pkg::xr_addr_t addr,
                               input copp_isa_pkg::word_t data,
                               input copp_bus_pkg::hres_t h);
        logic [31:0] exp;
        string       why;
        why = "";
        if (exp_q.size() == 0) begin
            why = "no write expected";
        end else begin
            exp = exp_q.pop_front();
            if ({addr, data} != exp) begin
                why = $sformatf("expected %h <= %h", exp[31:16], exp[15:0]);
            end else if (addr == MARKER_ADDR && h < hpos_target) begin
                why = $sformatf("marker at h=%0d before HPOS #%0d", h, hpos_target);
            end
        end
        assert (why == "") else begin
            $display("ERROR at %0t ns: XR write %h <= %h, %s", $time, addr, data, why);
            $display("Test failed");
            $fatal(1, "write check");
        end
    endtask

    task automatic clear_program();
        for (int i = 0; i < 2048; i++) begin
            mem[i] = fill_word(i);
        end
        load_pc = '0;
    endtask

    task automatic emit(input copp_isa_pkg::word_t w);
        mem[load_pc] = w;
        load_pc = load_pc + 1'b1;
    endtask

    task automatic emit_seti(input copp_isa_pkg::word_t xa, input copp_isa_pkg::word_t im);
        emit(xa & 16'hCFFF);                // opcode bits 13:12 are 00
        emit(im);
    endtask

    task automatic ctrl_write(input logic en);
        @(posedge clk);
        #5;
        cop_xreg_wr     = 1'b1;
        cop_xreg_enable = en;
        @(posedge clk);
        #5;
        cop_xreg_wr = 1'b0;
    endtask

    // enable, let the next frame run the program, then stop
    task automatic run_program();
        ctrl_write(1'b1);
        while (exp_q.size() != 0) @(posedge clk);
        ctrl_write(1'b0);
    endtask

    task automatic branch_test(input logic lt, input copp_isa_pkg::word_t a,
                               input copp_isa_pkg::word_t b);
        copp_isa_pkg::word_t ra;
        logic                borrow;
        ra     = a - b;
        borrow = ra < b;                    // B: RA against last value written
        clear_program();
        emit_seti(16'h0800, a);
        emit_seti(16'h0801, b);
        emit(brcc_word(lt, 11'd9));
        emit_seti(16'h4010, 16'hAAAA);      // fall-through path
        emit(hv_word(1'b1, 11'h7FF));
        load_pc = 11'd9;
        emit_seti(16'h4011, 16'hBBBB);      // branch target
        emit(hv_word(1'b1, 11'h7FF));
        if (borrow == lt) begin
            exp_q.push_back({16'h4011, 16'hBBBB});
        end else begin
            exp_q.push_back({16'h4010, 16'hAAAA});
        end
        run_program();
    endtask

    initial begin
        copp_isa_pkg::word_t w0;
        copp_isa_pkg::word_t w1;
        copp_isa_pkg::word_t w2;
        copp_isa_pkg::word_t xa;
        copp_isa_pkg::copp_addr_t src;
        void'($urandom(32'h83936ac7));
        cop_reset       = 1'b1;
        cop_xreg_wr     = 1'b0;
        cop_xreg_enable = 1'b0;
        hpos_target     = '0;
        clear_program();
        repeat (8) @(posedge clk);
        #5 cop_reset = 1'b0;

        // SETI into three regions
        clear_program();
        w0 = copp_isa_pkg::word_t'($urandom);
        w1 = copp_isa_pkg::word_t'($urandom);
        w2 = copp_isa_pkg::word_t'($urandom);
        xa = {4'b0100, 12'($urandom)};
        emit_seti(xa, w0);
        exp_q.push_back({xa, w0});
        xa = {4'b1100, 12'($urandom)};
        emit_seti(xa, w1);
        exp_q.push_back({xa, w1});
        xa = {5'b00000, 11'($urandom)};    // config region, below the RA registers
        emit_seti(xa, w2);
        exp_q.push_back({xa, w2});
        emit(hv_word(1'b1, 11'h7FF));
        run_program();

        // SETM from memory
        clear_program();
        src = 11'h700 + 11'($urandom_range(63, 0));
        xa  = {4'b1000, 12'($urandom)};
        emit({5'b00010, src});
        emit(xa);
        emit(hv_word(1'b1, 11'h7FF));
        exp_q.push_back({xa, fill_word(int'(src))});
        run_program();

        // RA load, subtract, then SETM from RA
        clear_program();
        w0 = copp_isa_pkg::word_t'($urandom);
        w1 = copp_isa_pkg::word_t'($urandom);
        emit_seti(16'h0800, w0);
        emit_seti(16'h0801, w1);
        emit({5'b00011, 11'h000});
        emit(16'h4123);
        emit(hv_word(1'b1, 11'h7FF));
        exp_q.push_back({16'h4123, copp_isa_pkg::word_t'(w0 - w1)});
        run_program();

        // both branches, with and without borrow
        branch_test(1'b1, 16'd100, 16'd30);
        branch_test(1'b1, 16'd50, 16'd30);
        branch_test(1'b0, 16'd100, 16'd30);
        branch_test(1'b0, 16'd50, 16'd30);

        // HPOS marker, VPOS #-1 holds until the next frame
        clear_program();
        hpos_target = 11'd20 + 11'($urandom_range(30, 0));
        w0 = copp_isa_pkg::word_t'($urandom);
        emit_seti(16'h4020, w0);
        emit(hv_word(1'b0, hpos_target));
        emit_seti(MARKER_ADDR, 16'h1234);
        emit(hv_word(1'b1, 11'h7FF));
        emit_seti(16'h4022, 16'hDEAD);      // never reached
        repeat (2) begin
            exp_q.push_back({16'h4020, w0});
            exp_q.push_back({MARKER_ADDR, 16'h1234});
        end
        run_program();

        // disable mid program, restart only at the next frame
        clear_program();
        w0 = copp_isa_pkg::word_t'($urandom);
        w1 = copp_isa_pkg::word_t'($urandom);
        emit_seti(16'h4030, w0);
        emit(hv_word(1'b1, 11'd5));
        emit_seti(16'h4031, w1);
        emit(hv_word(1'b1, 11'h7FF));
        exp_q.push_back({16'h4030, w0});
        run_program();                      // stops while waiting on line 5
        exp_q.push_back({16'h4030, w0});
        exp_q.push_back({16'h4031, w1});
        while (video.v != 11'd10) @(posedge clk);
        run_program();

        if (exp_q.size() == 0) begin
            $display("Test passed");
            $finish;
        end else begin
            $display("Test failed");
            $fatal(1, "expected writes left over");
        end
    end

endmodule

// ==== build.f ====
source/copp_isa_pkg.sv
source/copp_bus_pkg.sv
source/copp_ctrl.sv
source/copp_hv_wait.sv
source/copp_ra_unit.sv
source/copp_sequencer.sv
source/slim_copper.sv
bench/copper_tb_chk.sv
bench/copper_tb.sv

// ==== run.sh ====
#!/bin/sh
# build and run the slim copper testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert \
    -f build.f \
    --top-module copper_tb \
    -o copper_sim

./obj_dir/copper_sim
